/* filelist.f */
+incdir+src
+incdir+verification
src/riscv_pkg.sv
src/exec_pkg.sv
src/exec_alu.sv
src/exec_branch_cmp.sv
src/exec_stage.sv
verification/exec_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert --top-module exec_stage_tb \
    -f filelist.f --Mdir "$BUILD" -o exec_stage_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD/exec_stage_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
    exit 1
fi
exit 0

/* verification/exec_tb_model.svh */
//====================
// reference model for the execute stage testbench
// operand selects, ALU, branch compare, CSR update, LCG
//====================

// numerical recipes constants
function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

function automatic word_t model_op1(input d_to_e_s d);
    case (d.alu_op1_src)
        ALU_OP1_SRC_RS1: return d.rs1_val;
        ALU_OP1_SRC_PC:  return d.pc_word;
        ALU_OP1_SRC_CSR: return d.csr_old_val;
        default:         return 32'd0;
    endcase
endfunction

// FOUR is the link offset for jal/jalr
function automatic word_t model_op2(input d_to_e_s d);
    case (d.alu_op2_src)
        ALU_OP2_SRC_RS1: return d.rs1_val;
        ALU_OP2_SRC_RS2: return d.rs2_val;
        ALU_OP2_SRC_IMM: return d.immediate;
        default:         return 32'd4;
    endcase
endfunction

function automatic word_t model_alu(input word_t a, input word_t b, input alu_op_e op);
    logic [4:0]  sh;
    logic [63:0] ext;
    sh  = b[4:0];
    // sign extended to 64 bits, then a logical shift
    ext = {{32{a[31]}}, a} >> sh;
    case (op)
        ALU_OP_ADD:  return a + b;
        ALU_OP_SUB:  return a - b;
        ALU_OP_SLL:  return a << sh;
        // flipping the sign bit turns signed order into unsigned order
        ALU_OP_SLT:  return word_t'((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000));
        ALU_OP_SLTU: return word_t'(a < b);
        ALU_OP_XOR:  return a ^ b;
        ALU_OP_SRL:  return a >> sh;
        ALU_OP_SRA:  return ext[31:0];
        ALU_OP_OR:   return a | b;
        ALU_OP_AND:  return a & b;
        default:     return 32'd0;
    endcase
endfunction

function automatic logic model_cmp(input word_t a, input word_t b, input cmp_op_e op);
    logic lt_s;
    lt_s = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
    case (op)
        CMP_OP_EQ:  return a == b;
        CMP_OP_NE:  return a != b;
        CMP_OP_LT:  return lt_s;
        CMP_OP_GE:  return !lt_s;
        CMP_OP_LTU: return a < b;
        CMP_OP_GEU: return a >= b;
        default:    return 1'b0;
    endcase
endfunction

// csrrw / csrrs / csrrc, register or zimm operand
function automatic word_t model_csr(input d_to_e_s d);
    word_t operand;
    operand = (d.csr_op_src == CSR_OP_SRC_ZIMM) ? word_t'(d.csr_zimm) : d.rs1_val;
    case (d.csr_alu_op)
        CSR_ALU_OP_PASSTHRU: return operand;
        CSR_ALU_OP_BITSET:   return d.csr_old_val | operand;
        CSR_ALU_OP_BITCLEAR: return d.csr_old_val & ~operand;
        default:             return d.csr_old_val;
    endcase
endfunction

/* verification/exec_stage_tb.sv */
//====================
// exec_stage_tb
// random and directed instructions into the execute
// stage, outputs checked by concurrent assertions
//====================

`default_nettype none

`include "exec_params.svh"

module exec_stage_tb;

    import riscv_pkg::*;
    import exec_pkg::*;

    `include "exec_tb_model.svh"

    localparam int WAIT_LIMIT = 16;

    // signed/unsigned corner pairs for the comparator
    localparam word_t EDGE_A [3] = '{32'h8000_0000, 32'hffff_ffff, 32'h7fff_ffff};
    localparam word_t EDGE_B [3] = '{32'h0000_0001, 32'h0000_0000, 32'h8000_0000};

    logic     clk;
    logic     rst_n;
    logic     stall;
    logic     flush;
    logic     d_to_e_valid;
    d_to_e_s  d_to_e;
    logic     e_to_m1_valid;
    e_to_m1_s e_to_m1;

    // shadow of the stage register, one cycle behind the inputs
    logic    shadow_valid;
    d_to_e_s shadow;

    logic [31:0] lcg_state;
    int          err_cnt;
    int          err_mark;
    int          pass_cnt;
    int          fail_cnt;

    exec_stage DUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall         (stall),
        .flush         (flush),
        .d_to_e_valid  (d_to_e_valid),
        .d_to_e        (d_to_e),
        .e_to_m1_valid (e_to_m1_valid),
        .e_to_m1       (e_to_m1)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            shadow_valid <= 1'b0;
        end else if (!stall) begin
            shadow_valid <= d_to_e_valid;
            shadow       <= d_to_e;
        end
    end

    task automatic report_mismatch(input string field);
        $display("mismatch at time %0t: %s", $time, field);
        err_cnt++;
    endtask

    function automatic logic passthru_ok(input e_to_m1_s e, input d_to_e_s d);
        return e.pc_word == d.pc_word && e.rd_src == d.rd_src && e.rd_idx == d.rd_idx
            && e.rd_we == d.rd_we && e.csr_idx == d.csr_idx
            && e.csr_old_val == d.csr_old_val && e.rs1_idx == d.rs1_idx
            && e.rs2_idx == d.rs2_idx && e.memory_op == d.memory_op
            && e.memory_signed == d.memory_signed && e.memory_size == d.memory_size
            && e.rs2_val == d.rs2_val;
    endfunction

    // exactly one cycle of latency, nothing out under stall or flush
    a_valid: assert property (@(posedge clk) disable iff (!rst_n)
        e_to_m1_valid == (shadow_valid && !stall && !flush))
        else report_mismatch("e_to_m1_valid");

    a_alu_result: assert property (@(posedge clk) disable iff (!rst_n)
        e_to_m1_valid |-> e_to_m1.alu_result
            == model_alu(model_op1(shadow), model_op2(shadow), shadow.alu_op))
        else report_mismatch("alu_result");

    a_branch_taken: assert property (@(posedge clk) disable iff (!rst_n)
        e_to_m1_valid |-> e_to_m1.branch_taken
            == model_cmp(shadow.rs1_val, shadow.rs2_val, shadow.cmp_op))
        else report_mismatch("branch_taken");

    a_csr_new_val: assert property (@(posedge clk) disable iff (!rst_n)
        e_to_m1_valid |-> e_to_m1.csr_new_val == model_csr(shadow))
        else report_mismatch("csr_new_val");

    a_pass_through: assert property (@(posedge clk) disable iff (!rst_n)
        e_to_m1_valid |-> passthru_ok(e_to_m1, shadow))
        else report_mismatch("pass-through fields");

    function automatic word_t rand_word();
        lcg_state = lcg_next(lcg_state);
        // fold the better upper bits down
        return lcg_state ^ (lcg_state >> 13);
    endfunction

    // every field random, encodings kept legal
    function automatic d_to_e_s rand_instr();
        d_to_e_s d;
        word_t   r;
        d.pc_word     = rand_word() & 32'hffff_fffc;
        d.rs1_val     = rand_word();
        d.rs2_val     = rand_word();
        d.immediate   = rand_word();
        d.csr_old_val = rand_word();
        r = rand_word();
        d.rs1_idx       = r[4:0];
        d.rs2_idx       = r[9:5];
        d.rd_idx        = r[14:10];
        d.rd_we         = r[15];
        d.csr_zimm      = r[16 +: `EXEC_ZIMM_W];
        d.memory_signed = r[21];
        d.rd_src        = rd_src_e'(r[23:22]);
        d.csr_op_src    = csr_op_src_e'(r[24]);
        d.alu_op1_src   = alu_op1_src_e'(r[26:25]);
        d.alu_op2_src   = alu_op2_src_e'(r[28:27]);
        r = rand_word();
        d.csr_idx     = r[11:0];
        d.cmp_op      = cmp_op_e'(3'(r[19:12] % 8'd6));
        d.csr_alu_op  = csr_alu_op_e'(2'(r[27:20] % 8'd3));
        r = rand_word();
        d.alu_op      = alu_op_e'(4'(r[15:0] % 16'd10));
        d.memory_op   = mem_op_e'(2'(r[23:16] % 8'd3));
        d.memory_size = mem_size_e'(2'(r[31:24] % 8'd3));
        return d;
    endfunction

    // output valid seen at a falling edge, bounded
    task automatic wait_output();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!e_to_m1_valid && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        if (!e_to_m1_valid) begin
            $display("timeout: no valid output within %0d cycles", WAIT_LIMIT);
            $display("Simulation finished: FAIL");
            $finish;
        end
    endtask

    // one instruction in, then wait for it at the output
    task automatic send(input d_to_e_s instr);
        @(posedge clk);
        d_to_e       <= instr;
        d_to_e_valid <= 1'b1;
        @(posedge clk);
        d_to_e_valid <= 1'b0;
        wait_output();
    endtask

    task automatic end_test(input string name);
        // let the last output reach its checking edge
        repeat (2) @(negedge clk);
        if (err_cnt == err_mark) begin
            pass_cnt++;
            $display("test %s: ok", name);
        end else begin
            fail_cnt++;
            $display("test %s: failed with %0d mismatches", name, err_cnt - err_mark);
        end
        err_mark = err_cnt;
    endtask

    task automatic test_alu();
        d_to_e_s d;
        for (int op = 0; op < 10; op++) begin
            for (int s1 = 0; s1 < 4; s1++) begin
                for (int s2 = 0; s2 < 4; s2++) begin
                    d = rand_instr();
                    d.alu_op      = alu_op_e'(4'(op));
                    d.alu_op1_src = alu_op1_src_e'(2'(s1));
                    d.alu_op2_src = alu_op2_src_e'(2'(s2));
                    send(d);
                end
            end
        end
        end_test("alu operations and sources");
    endtask

    // k 0 and 5 random, 1 equal, 2..4 corner pairs
    task automatic test_branch();
        d_to_e_s d;
        for (int op = 0; op < 6; op++) begin
            for (int k = 0; k < 6; k++) begin
                d = rand_instr();
                d.cmp_op = cmp_op_e'(3'(op));
                if (k == 1) begin
                    d.rs2_val = d.rs1_val;
                end else if (k >= 2 && k <= 4) begin
                    d.rs1_val = EDGE_A[k-2];
                    d.rs2_val = EDGE_B[k-2];
                end
                send(d);
            end
        end
        end_test("branch compare");
    endtask

    task automatic test_csr();
        d_to_e_s d;
        for (int op = 0; op < 3; op++) begin
            for (int src = 0; src < 2; src++) begin
                repeat (4) begin
                    d = rand_instr();
                    d.csr_alu_op = csr_alu_op_e'(2'(op));
                    d.csr_op_src = csr_op_src_e'(1'(src));
                    send(d);
                end
            end
        end
        end_test("csr update");
    endtask

    task automatic test_stall();
        d_to_e_s held;
        held = rand_instr();
        @(posedge clk);
        d_to_e       <= held;
        d_to_e_valid <= 1'b1;
        @(posedge clk);
        // a new payload under stall must not replace the held one
        d_to_e <= rand_instr();
        stall  <= 1'b1;
        repeat (4) @(posedge clk);
        stall        <= 1'b0;
        d_to_e_valid <= 1'b0;
        wait_output();
        assert (passthru_ok(e_to_m1, held))
            else report_mismatch("held instruction after stall");
        end_test("stall hold");
    endtask

    task automatic test_flush();
        d_to_e_s first;
        d_to_e_s second;
        first  = rand_instr();
        second = rand_instr();
        @(posedge clk);
        d_to_e       <= first;
        d_to_e_valid <= 1'b1;
        // first sits in the register during the flush cycle
        @(posedge clk);
        d_to_e <= second;
        flush  <= 1'b1;
        @(posedge clk);
        flush        <= 1'b0;
        d_to_e_valid <= 1'b0;
        wait_output();
        assert (passthru_ok(e_to_m1, second))
            else report_mismatch("instruction after flush");
        end_test("flush");
    endtask

    initial begin
        lcg_state    = 32'd92892;
        err_cnt      = 0;
        err_mark     = 0;
        pass_cnt     = 0;
        fail_cnt     = 0;
        rst_n        = 1'b0;
        stall        = 1'b0;
        flush        = 1'b0;
        d_to_e_valid = 1'b0;
        d_to_e       = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        // quiet cycles first, output must stay low
        repeat (3) @(posedge clk);
        send(rand_instr());
        end_test("reset and latency");
        test_alu();
        test_branch();
        test_csr();
        test_stall();
        test_flush();
        $display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule : exec_stage_tb

`default_nettype wire

/* src/exec_stage.sv */
//====================
// exec_stage
// execute stage of the RV32I pipeline with the input
// register, ALU and branch compare in parallel, Zicsr
// update and the result struct to memory stage 1
//====================

`default_nettype none

`include "exec_params.svh"

module exec_stage (
    input  logic               clk,
    input  logic               rst_n,

    // hazard control from the pipeline controller
    input  logic               stall,
    input  logic               flush,

    // from decode
    input  logic               d_to_e_valid,
    input  exec_pkg::d_to_e_s  d_to_e,

    // to memory stage 1
    output logic               e_to_m1_valid,
    output exec_pkg::e_to_m1_s e_to_m1
);

    import riscv_pkg::*;
    import exec_pkg::*;

    // registered instruction
    logic    ff_in_valid;
    d_to_e_s ff_in;

    // alu side
    word_t alu_operand_a;
    word_t alu_operand_b;
    word_t alu_result;

    // branch side
    logic cmp_result;

    // csr side
    word_t csr_operand;
    word_t csr_new_val;

    // valid bit cleared by reset and held under stall
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ff_in_valid <= 1'b0;
        end else if (!stall) begin
            ff_in_valid <= d_to_e_valid;
        end
    end

    // payload loads on the same edges as the valid bit
    always_ff @(posedge clk) begin
        if (!stall) begin
            ff_in <= d_to_e;
        end
    end

    // op1 select
    always_comb begin
        case (ff_in.alu_op1_src)
            ALU_OP1_SRC_RS1:  alu_operand_a = ff_in.rs1_val;
            ALU_OP1_SRC_PC:   alu_operand_a = ff_in.pc_word;
            ALU_OP1_SRC_CSR:  alu_operand_a = ff_in.csr_old_val;
            default:          alu_operand_a = '0;
        endcase
    end

    // op2 select
    // four is the link address offset
    always_comb begin
        case (ff_in.alu_op2_src)
            ALU_OP2_SRC_RS1:  alu_operand_b = ff_in.rs1_val;
            ALU_OP2_SRC_RS2:  alu_operand_b = ff_in.rs2_val;
            ALU_OP2_SRC_IMM:  alu_operand_b = ff_in.immediate;
            default:          alu_operand_b = word_t'(4);
        endcase
    end

    exec_alu u_alu (
        .operand_a  (alu_operand_a),
        .operand_b  (alu_operand_b),
        .alu_op     (ff_in.alu_op),
        .alu_result (alu_result)
    );

    // branch compare works on raw rs1/rs2 alongside the ALU
    exec_branch_cmp u_branch_cmp (
        .rs1_val    (ff_in.rs1_val),
        .rs2_val    (ff_in.rs2_val),
        .cmp_op     (ff_in.cmp_op),
        .cmp_result (cmp_result)
    );

    // csr operand is rs1 or the zero-extended zimm
    always_comb begin
        if (ff_in.csr_op_src == CSR_OP_SRC_ZIMM) begin
            csr_operand = {{(`EXEC_XLEN-`EXEC_ZIMM_W){1'b0}}, ff_in.csr_zimm};
        end else begin
            csr_operand = ff_in.rs1_val;
        end
    end

    // csrrw writes the operand, csrrs sets bits, csrrc clears them
    always_comb begin
        case (ff_in.csr_alu_op)
            CSR_ALU_OP_PASSTHRU: csr_new_val = csr_operand;
            CSR_ALU_OP_BITSET:   csr_new_val = ff_in.csr_old_val | csr_operand;
            CSR_ALU_OP_BITCLEAR: csr_new_val = ff_in.csr_old_val & ~csr_operand;
            default:             csr_new_val = ff_in.csr_old_val;
        endcase
    end

    // output valid drops for a flush or a stall cycle
    assign e_to_m1_valid = ff_in_valid && !flush && !stall;

    // results plus pass-through fields
    always_comb begin
        e_to_m1.pc_word       = ff_in.pc_word;
        e_to_m1.rd_src        = ff_in.rd_src;
        e_to_m1.rd_idx        = ff_in.rd_idx;
        e_to_m1.rd_we         = ff_in.rd_we;
        e_to_m1.csr_idx       = ff_in.csr_idx;
        e_to_m1.csr_old_val   = ff_in.csr_old_val;
        e_to_m1.csr_new_val   = csr_new_val;
        e_to_m1.rs1_idx       = ff_in.rs1_idx;
        e_to_m1.rs2_idx       = ff_in.rs2_idx;
        e_to_m1.alu_result    = alu_result;
        e_to_m1.memory_op     = ff_in.memory_op;
        e_to_m1.memory_signed = ff_in.memory_signed;
        e_to_m1.memory_size   = ff_in.memory_size;
        e_to_m1.rs2_val       = ff_in.rs2_val;
        e_to_m1.branch_taken  = cmp_result;
    end

    // controller never asks for both at once
    a_no_stall_and_flush: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(stall && flush)
    ) else $error("exec_stage: stall and flush high together");

    // an instruction held by a stall leaves once the stall drops
    a_held_valid_after_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        $past(stall) && $past(ff_in_valid) && !stall && !flush |-> e_to_m1_valid
    ) else $error("exec_stage: held instruction lost across stall");

    // a captured instruction carries a legal ALU encoding
    a_alu_op_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        ff_in_valid |-> ff_in.alu_op inside {
            ALU_OP_ADD, ALU_OP_SUB, ALU_OP_SLL, ALU_OP_SLT, ALU_OP_SLTU,
            ALU_OP_XOR, ALU_OP_SRL, ALU_OP_SRA, ALU_OP_OR, ALU_OP_AND
        }
    ) else $error("exec_stage: unknown alu_op in registered instruction");

endmodule : exec_stage

`default_nettype wire

/* src/exec_branch_cmp.sv */
//====================
// exec_branch_cmp
// branch condition for beq/bne/blt/bge/bltu/bgeu
//====================

`default_nettype none

module exec_branch_cmp (
    input  riscv_pkg::word_t  rs1_val,
    input  riscv_pkg::word_t  rs2_val,
    input  exec_pkg::cmp_op_e cmp_op,
    output logic              cmp_result
);

    import exec_pkg::*;

    // three base comparisons
    logic is_eq;
    logic is_lt;
    logic is_ltu;

    assign is_eq  = (rs1_val == rs2_val);
    assign is_lt  = $signed(rs1_val) < $signed(rs2_val);
    assign is_ltu = rs1_val < rs2_val;

    // ne/ge/geu are the inverses
    always_comb begin
        case (cmp_op)
            CMP_OP_EQ: begin
                cmp_result = is_eq;
            end
            CMP_OP_NE: begin
                cmp_result = !is_eq;
            end
            CMP_OP_LT: begin
                cmp_result = is_lt;
            end
            CMP_OP_GE: begin
                cmp_result = !is_lt;
            end
            CMP_OP_LTU: begin
                cmp_result = is_ltu;
            end
            CMP_OP_GEU: begin
                cmp_result = !is_ltu;
            end
            // never taken on a bad encoding
            default: begin
                cmp_result = 1'b0;
            end
        endcase
    end

endmodule : exec_branch_cmp

`default_nettype wire

/* src/exec_alu.sv */
//====================
// exec_alu
// RV32I integer ALU, purely combinational:
// add/sub, shifts, logic ops, set-less-than
//====================

`default_nettype none

`include "exec_params.svh"

module exec_alu (
    input  riscv_pkg::word_t   operand_a,
    input  riscv_pkg::word_t   operand_b,
    input  exec_pkg::alu_op_e  alu_op,
    output riscv_pkg::word_t   alu_result
);

    import riscv_pkg::*;
    import exec_pkg::*;

    localparam int SHAMT_W = $clog2(`EXEC_XLEN);

    // one adder for add and sub
    logic  is_sub;
    word_t adder_b;
    word_t adder_sum;

    // shift amount, low bits of operand b only
    logic [SHAMT_W-1:0] shamt;

    // comparison results for slt/sltu
    logic lt_signed;
    logic lt_unsigned;

    assign is_sub = (alu_op == ALU_OP_SUB);

    // two's complement subtract: a + ~b + 1
    assign adder_b   = is_sub ? ~operand_b : operand_b;
    assign adder_sum = operand_a + adder_b + {{(`EXEC_XLEN-1){1'b0}}, is_sub};

    assign shamt = operand_b[SHAMT_W-1:0];

    assign lt_signed   = $signed(operand_a) < $signed(operand_b);
    assign lt_unsigned = operand_a < operand_b;

    always_comb begin
        case (alu_op)
            ALU_OP_ADD,
            ALU_OP_SUB: begin
                alu_result = adder_sum;
            end
            ALU_OP_SLL: begin
                alu_result = operand_a << shamt;
            end
            // result is 0 or 1, zero extended
            ALU_OP_SLT: begin
                alu_result = {{(`EXEC_XLEN-1){1'b0}}, lt_signed};
            end
            ALU_OP_SLTU: begin
                alu_result = {{(`EXEC_XLEN-1){1'b0}}, lt_unsigned};
            end
            ALU_OP_XOR: begin
                alu_result = operand_a ^ operand_b;
            end
            ALU_OP_SRL: begin
                alu_result = operand_a >> shamt;
            end
            // arithmetic shift keeps the sign bit
            ALU_OP_SRA: begin
                alu_result = word_t'($signed(operand_a) >>> shamt);
            end
            ALU_OP_OR: begin
                alu_result = operand_a | operand_b;
            end
            ALU_OP_AND: begin
                alu_result = operand_a & operand_b;
            end
            // unused encodings
            default: begin
                alu_result = '0;
            end
        endcase
    end

endmodule : exec_alu

`default_nettype wire

/* src/exec_pkg.sv */
//====================
// exec_pkg
// pipeline types around the execute stage:
// operation encodings, operand selects and
// the decode/execute/memory stage structs
//====================

`default_nettype none

`include "exec_params.svh"

package exec_pkg;

    import riscv_pkg::*;

    // integer ALU operations
    typedef enum logic [3:0] {
        ALU_OP_ADD  = 4'd0,
        ALU_OP_SUB  = 4'd1,
        ALU_OP_SLL  = 4'd2,
        ALU_OP_SLT  = 4'd3,
        ALU_OP_SLTU = 4'd4,
        ALU_OP_XOR  = 4'd5,
        ALU_OP_SRL  = 4'd6,
        ALU_OP_SRA  = 4'd7,
        ALU_OP_OR   = 4'd8,
        ALU_OP_AND  = 4'd9
    } alu_op_e;

    // branch conditions, funct3 order minus the gaps
    typedef enum logic [2:0] {
        CMP_OP_EQ  = 3'd0,
        CMP_OP_NE  = 3'd1,
        CMP_OP_LT  = 3'd2,
        CMP_OP_GE  = 3'd3,
        CMP_OP_LTU = 3'd4,
        CMP_OP_GEU = 3'd5
    } cmp_op_e;

    // first ALU operand
    typedef enum logic [1:0] {
        ALU_OP1_SRC_RS1  = 2'd0,
        ALU_OP1_SRC_PC   = 2'd1,
        ALU_OP1_SRC_CSR  = 2'd2,
        ALU_OP1_SRC_ZERO = 2'd3
    } alu_op1_src_e;

    // second ALU operand, FOUR gives pc+4 for jal/jalr
    typedef enum logic [1:0] {
        ALU_OP2_SRC_RS1  = 2'd0,
        ALU_OP2_SRC_RS2  = 2'd1,
        ALU_OP2_SRC_IMM  = 2'd2,
        ALU_OP2_SRC_FOUR = 2'd3
    } alu_op2_src_e;

    // csr operand, register or zimm form
    typedef enum logic {
        CSR_OP_SRC_RS1  = 1'b0,
        CSR_OP_SRC_ZIMM = 1'b1
    } csr_op_src_e;

    // csrrw / csrrs / csrrc
    typedef enum logic [1:0] {
        CSR_ALU_OP_PASSTHRU = 2'd0,
        CSR_ALU_OP_BITSET   = 2'd1,
        CSR_ALU_OP_BITCLEAR = 2'd2
    } csr_alu_op_e;

    // writeback source, consumed further down the pipe
    typedef enum logic [1:0] {
        RD_SRC_ALU    = 2'd0,
        RD_SRC_MEM    = 2'd1,
        RD_SRC_CSR    = 2'd2,
        RD_SRC_BRANCH = 2'd3
    } rd_src_e;

    typedef enum logic [1:0] {
        MEM_OP_NONE  = 2'd0,
        MEM_OP_LOAD  = 2'd1,
        MEM_OP_STORE = 2'd2
    } mem_op_e;

    typedef enum logic [1:0] {
        MEM_SIZE_BYTE = 2'd0,
        MEM_SIZE_HALF = 2'd1,
        MEM_SIZE_WORD = 2'd2
    } mem_size_e;

    // decode to execute
    typedef struct packed {
        word_t                   pc_word;
        word_t                   rs1_val;
        word_t                   rs2_val;
        word_t                   immediate;
        word_t                   csr_old_val;
        reg_idx_t                rs1_idx;
        reg_idx_t                rs2_idx;
        reg_idx_t                rd_idx;
        logic                    rd_we;
        rd_src_e                 rd_src;
        csr_idx_t                csr_idx;
        logic [`EXEC_ZIMM_W-1:0] csr_zimm;
        alu_op_e                 alu_op;
        alu_op1_src_e            alu_op1_src;
        alu_op2_src_e            alu_op2_src;
        cmp_op_e                 cmp_op;
        csr_op_src_e             csr_op_src;
        csr_alu_op_e             csr_alu_op;
        mem_op_e                 memory_op;
        logic                    memory_signed;
        mem_size_e               memory_size;
    } d_to_e_s;

    // execute to memory stage 1
    typedef struct packed {
        word_t     pc_word;
        rd_src_e   rd_src;
        reg_idx_t  rd_idx;
        logic      rd_we;
        csr_idx_t  csr_idx;
        word_t     csr_old_val;
        word_t     csr_new_val;
        reg_idx_t  rs1_idx;
        reg_idx_t  rs2_idx;
        word_t     alu_result;
        mem_op_e   memory_op;
        logic      memory_signed;
        mem_size_e memory_size;
        // store data
        word_t     rs2_val;
        logic      branch_taken;
    } e_to_m1_s;

endpackage : exec_pkg

`default_nettype wire

/* src/riscv_pkg.sv */
//====================
// riscv_pkg
// ISA-level types for the RV32I pipeline:
// data words, register and CSR indices
//====================

`default_nettype none

`include "exec_params.svh"

package riscv_pkg;

    // one integer register or CSR value
    typedef logic [`EXEC_XLEN-1:0] word_t;

    // x0..x31
    typedef logic [4:0] reg_idx_t;

    // csr address space, 4096 entries
    typedef logic [11:0] csr_idx_t;

endpackage : riscv_pkg

`default_nettype wire

/* src/exec_params.svh */
//====================
// execute stage parameters
// data word width and CSR immediate width
//====================

`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// data word width, RV32
`define EXEC_XLEN 32

// zimm field of csrrwi/csrrsi/csrrci
// zero extended to a full word before use
`define EXEC_ZIMM_W 5

`endif
